// File: common/io_pkg.sv
// centipede I/O address map, latch bit positions and width types
`default_nettype none

package io_pkg;

   // widths that carry a meaning
   typedef logic [13:0] io_addr_t;
   typedef logic [7:0]  io_data_t;
   typedef logic [3:0]  trak_cnt_t;

   // address decode window, only bits 13:10 take part in the compare
   localparam int ADDR_MATCH_HI = 13;
   localparam int ADDR_MATCH_LO = 10;

   // base addresses of the kept locations
   localparam io_addr_t ADDR_SWRD     = 14'h0800;
   localparam io_addr_t ADDR_IN       = 14'h0C00;
   localparam io_addr_t ADDR_OUT0     = 14'h1C00;
   localparam io_addr_t ADDR_STEERCLR = 14'h2400;

   // address bit that picks in1 over in0
   localparam int ADDR_IN_SEL = 1;

   // out0 latch bit positions
   localparam int LATCH_FLIP    = 7;
   localparam int LATCH_LED_LO  = 3;
   localparam int LATCH_COIN_R  = 2;
   localparam int LATCH_COIN_CL = 1;

   // player input bit positions
   localparam int PIN_COIN_R    = 9;
   localparam int PIN_COIN_C    = 8;
   localparam int PIN_COIN_L    = 7;
   localparam int PIN_SELF_TEST = 6;
   localparam int PIN_COCKTAIL  = 5;
   localparam int PIN_SLAM      = 4;
   localparam int PIN_START1    = 3;
   localparam int PIN_START2    = 2;
   localparam int PIN_FIRE2     = 1;
   localparam int PIN_FIRE1     = 0;

endpackage

`default_nettype wire

// File: common/bus_pkg.sv
// centipede I/O bus, decoded access and trackball signal bundles
`default_nettype none

package bus_pkg;

   import io_pkg::*;

   // one CPU bus cycle, at most one of rd and wr set
   typedef struct packed {
      io_addr_t addr;
      io_data_t wdata;
      logic     wr;
      logic     rd;
   } cpu_bus_t;

   // which I/O location an access hits
   typedef enum logic [2:0] {
      SEL_NONE,
      SEL_IN0,
      SEL_IN1,
      SEL_SWRD,
      SEL_OUT0,
      SEL_STEERCLR
   } io_sel_e;

   // decoded access as seen by the register and read stages
   typedef struct packed {
      io_sel_e    sel;
      logic [2:0] lsb;
      logic       data_bit;
      logic       wr;
      logic       rd;
      logic       ab0;
   } io_access_t;

   // selected player's trackball lines
   typedef struct packed {
      logic h_dir;
      logic h_ck;
      logic v_dir;
      logic v_ck;
   } trak_pair_t;

endpackage

`default_nettype wire

// File: rtl/addr_decode.sv
// I/O address decoder, turns each bus strobe into one registered access
`default_nettype none
`timescale 1ns/100ps

module addr_decode
   import io_pkg::*, bus_pkg::*;
(
   input  wire logic       s_6mhz,
   input  wire logic       reset,
   input  wire cpu_bus_t   bus_i,
   output      io_access_t acc_o
);

   io_sel_e    sel;
   io_access_t acc_q;
   logic [3:0] blk;

   // 1k block number of the address
   assign blk = bus_i.addr[ADDR_MATCH_HI:ADDR_MATCH_LO];

   always_comb
   begin
      if (blk == ADDR_SWRD[ADDR_MATCH_HI:ADDR_MATCH_LO])
         sel = SEL_SWRD;
      else if (blk == ADDR_IN[ADDR_MATCH_HI:ADDR_MATCH_LO])
         sel = bus_i.addr[ADDR_IN_SEL] ? SEL_IN1 : SEL_IN0;
      else if (blk == ADDR_OUT0[ADDR_MATCH_HI:ADDR_MATCH_LO])
         sel = SEL_OUT0;
      else if (blk == ADDR_STEERCLR[ADDR_MATCH_HI:ADDR_MATCH_LO])
         sel = SEL_STEERCLR;
      else
         sel = SEL_NONE;
   end

   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
         acc_q <= '0;
      else
      begin
         acc_q.sel      <= sel;
         acc_q.lsb      <= bus_i.addr[2:0];
         acc_q.data_bit <= bus_i.wdata[7];
         acc_q.wr       <= bus_i.wr;
         acc_q.rd       <= bus_i.rd;
         acc_q.ab0      <= bus_i.addr[0];
      end
   end

   assign acc_o = acc_q;

   // the bus never reads and writes in the same cycle
   a_rd_wr_excl: assert property (@(posedge s_6mhz) disable iff (reset)
      !(bus_i.rd && bus_i.wr));

endmodule

`default_nettype wire

// File: rtl/coin_latch.sv
// out0 bit-addressable latch for coin counters, LEDs and flip, with coin forcing
`default_nettype none
`timescale 1ns/100ps

module coin_latch
   import io_pkg::*, bus_pkg::*;
(
   input  wire logic       s_6mhz,
   input  wire logic       reset,
   input  wire io_access_t acc_i,
   input  wire logic [9:0] player_i,
   output      logic       flip_o,
   output      logic [3:0] led_o,
   output      logic [2:0] coin_o
);

   logic [7:0] latch_q;

   // one latch bit per write, picked by address bits 2:0
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
         latch_q <= '0;
      else if (acc_i.sel == SEL_OUT0 && acc_i.wr)
         latch_q[acc_i.lsb] <= acc_i.data_bit;
   end

   assign flip_o = latch_q[LATCH_FLIP];
   assign led_o  = latch_q[LATCH_LED_LO +: 4];

   // a driven coin counter also reads back as an inserted coin
   // bit 1 drives both the centre and the left counter
   assign coin_o[2] = player_i[PIN_COIN_R] | latch_q[LATCH_COIN_R];
   assign coin_o[1] = player_i[PIN_COIN_C] | latch_q[LATCH_COIN_CL];
   assign coin_o[0] = player_i[PIN_COIN_L] | latch_q[LATCH_COIN_CL];

endmodule

`default_nettype wire

// File: trakball/trak_sync.sv
// trackball line synchronizer, player select by flip and clock edge detect
`default_nettype none
`timescale 1ns/100ps

module trak_sync
   import bus_pkg::*;
(
   input  wire logic       s_6mhz,
   input  wire logic       reset,
   input  wire logic [7:0] trakball_i,
   input  wire logic       flip_i,
   output      trak_pair_t trak_o,
   output      logic       h_step_o,
   output      logic       v_step_o
);

   logic [7:0] meta_q;
   logic [7:0] sync_q;
   trak_pair_t sel_lvl;
   trak_pair_t trak_q;
   logic       h_step_q;
   logic       v_step_q;

   // player 1 sits on the odd bits, player 2 on the even bits
   always_comb
   begin
      if (flip_i)
         sel_lvl = '{h_dir: sync_q[7], h_ck: sync_q[5], v_dir: sync_q[3], v_ck: sync_q[1]};
      else
         sel_lvl = '{h_dir: sync_q[6], h_ck: sync_q[4], v_dir: sync_q[2], v_ck: sync_q[0]};
   end

   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         meta_q   <= '0;
         sync_q   <= '0;
         trak_q   <= '0;
         h_step_q <= 1'b0;
         v_step_q <= 1'b0;
      end
      else
      begin
         meta_q   <= trakball_i;
         sync_q   <= meta_q;
         // trak_q holds the previous level, so a rise shows as new high, old low
         h_step_q <= sel_lvl.h_ck & ~trak_q.h_ck;
         v_step_q <= sel_lvl.v_ck & ~trak_q.v_ck;
         // direction is registered with the step so both line up
         trak_q   <= sel_lvl;
      end
   end

   assign trak_o   = trak_q;
   assign h_step_o = h_step_q;
   assign v_step_o = v_step_q;

endmodule

`default_nettype wire

// File: trakball/trak_counter.sv
// one trackball axis, four-bit up/down counter with direction bit and clear
`default_nettype none
`timescale 1ns/100ps

module trak_counter
   import io_pkg::*;
(
   input  wire logic      s_6mhz,
   input  wire logic      reset,
   input  wire logic      step_i,
   input  wire logic      dir_i,
   input  wire logic      clear_i,
   output      trak_cnt_t cnt_o,
   output      logic      dir_o
);

   trak_cnt_t cnt_q;
   logic      dir_q;

   // the direction bit follows the last step
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
         dir_q <= 1'b0;
      else if (step_i)
         dir_q <= dir_i;
   end

   // clear beats a step landing in the same cycle
   // the count wraps modulo 16 either way
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
         cnt_q <= '0;
      else if (clear_i)
         cnt_q <= '0;
      else if (step_i)
      begin
         if (dir_i)
            cnt_q <= cnt_q + 4'd1;
         else
            cnt_q <= cnt_q - 4'd1;
      end
   end

   assign cnt_o = cnt_q;
   assign dir_o = dir_q;

   // a step is a single-cycle pulse, so each clock rise counts once
   a_step_pulse: assert property (@(posedge s_6mhz) disable iff (reset)
      step_i |=> !step_i);

endmodule

`default_nettype wire

// File: rtl/input_mux.sv
// read stage, builds the in0, in1 and option bytes and registers the selected one
`default_nettype none
`timescale 1ns/100ps

module input_mux
   import io_pkg::*, bus_pkg::*;
(
   input  wire logic       s_6mhz,
   input  wire logic       reset,
   input  wire io_access_t acc_i,
   input  wire logic [9:0] player_i,
   input  wire logic [2:0] coin_i,
   input  wire logic [7:0] joystick_i,
   input  wire io_data_t   sw1_i,
   input  wire io_data_t   sw2_i,
   input  wire logic       vblank_i,
   input  wire trak_cnt_t  tra_i,
   input  wire trak_cnt_t  trb_i,
   input  wire logic       dir1_i,
   input  wire logic       dir2_i,
   output      io_data_t   rd_data_o,
   output      logic       rd_valid_o
);

   io_data_t in0_hi;
   io_data_t in0_lo;
   io_data_t in1_lo;
   io_data_t rd_byte;
   io_data_t data_q;
   logic     valid_q;

   // coins come in already forced by the out0 latch
   assign in0_hi = {coin_i, player_i[PIN_SLAM], player_i[PIN_FIRE2], player_i[PIN_FIRE1],
                    player_i[PIN_START1], player_i[PIN_START2]};
   assign in0_lo = {dir1_i, vblank_i, player_i[PIN_SELF_TEST], player_i[PIN_COCKTAIL], tra_i};
   assign in1_lo = {dir2_i, 3'b000, trb_i};

   // write-only and unmapped locations read back as zero
   always_comb
   begin
      case (acc_i.sel)
         SEL_IN0:  rd_byte = acc_i.ab0 ? in0_hi : in0_lo;
         SEL_IN1:  rd_byte = acc_i.ab0 ? joystick_i : in1_lo;
         SEL_SWRD: rd_byte = acc_i.ab0 ? sw2_i : sw1_i;
         default:  rd_byte = '0;
      endcase
   end

   always_ff @(posedge s_6mhz)
   begin
      if (acc_i.rd)
         data_q <= rd_byte;
   end

   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
         valid_q <= 1'b0;
      else
         valid_q <= acc_i.rd;
   end

   assign rd_data_o  = data_q;
   assign rd_valid_o = valid_q;

   // data flagged valid is fully known
   a_valid_data_known: assert property (@(posedge s_6mhz) disable iff (reset)
      rd_valid_o |-> !$isunknown(rd_data_o));

endmodule

`default_nettype wire

// File: rtl/centipede_io.sv
// centipede operator input and coin output I/O block, top level
`default_nettype none
`timescale 1ns/100ps

module centipede_io
   import io_pkg::*, bus_pkg::*;
(
   input  wire logic       s_6mhz,
   input  wire logic       reset,
   input  wire cpu_bus_t   bus_i,
   input  wire logic [9:0] player_i,
   input  wire logic [7:0] trakball_i,
   input  wire logic [7:0] joystick_i,
   input  wire io_data_t   sw1_i,
   input  wire io_data_t   sw2_i,
   input  wire logic       vblank_i,
   output      io_data_t   rd_data_o,
   output      logic       rd_valid_o,
   output      logic [3:0] led_o
);

   io_access_t acc;
   logic       flip;
   logic [2:0] coin;
   trak_pair_t trak;
   logic       h_step;
   logic       v_step;
   logic       steer_clr;
   trak_cnt_t  tra;
   trak_cnt_t  trb;
   logic       dir1;
   logic       dir2;

   addr_decode u_decode (
      .s_6mhz (s_6mhz),
      .reset  (reset),
      .bus_i  (bus_i),
      .acc_o  (acc)
   );

   coin_latch u_latch (
      .s_6mhz   (s_6mhz),
      .reset    (reset),
      .acc_i    (acc),
      .player_i (player_i),
      .flip_o   (flip),
      .led_o    (led_o),
      .coin_o   (coin)
   );

   trak_sync u_trak_sync (
      .s_6mhz     (s_6mhz),
      .reset      (reset),
      .trakball_i (trakball_i),
      .flip_i     (flip),
      .trak_o     (trak),
      .h_step_o   (h_step),
      .v_step_o   (v_step)
   );

   // steering clear resets both axes together
   assign steer_clr = (acc.sel == SEL_STEERCLR) && acc.wr;

   trak_counter u_trak_h (
      .s_6mhz  (s_6mhz),
      .reset   (reset),
      .step_i  (h_step),
      .dir_i   (trak.h_dir),
      .clear_i (steer_clr),
      .cnt_o   (tra),
      .dir_o   (dir1)
   );

   trak_counter u_trak_v (
      .s_6mhz  (s_6mhz),
      .reset   (reset),
      .step_i  (v_step),
      .dir_i   (trak.v_dir),
      .clear_i (steer_clr),
      .cnt_o   (trb),
      .dir_o   (dir2)
   );

   input_mux u_rd_mux (
      .s_6mhz     (s_6mhz),
      .reset      (reset),
      .acc_i      (acc),
      .player_i   (player_i),
      .coin_i     (coin),
      .joystick_i (joystick_i),
      .sw1_i      (sw1_i),
      .sw2_i      (sw2_i),
      .vblank_i   (vblank_i),
      .tra_i      (tra),
      .trb_i      (trb),
      .dir1_i     (dir1),
      .dir2_i     (dir2),
      .rd_data_o  (rd_data_o),
      .rd_valid_o (rd_valid_o)
   );

   // the selected trackball clocks hold each level for at least three cycles
   a_h_ck_stable: assert property (@(posedge s_6mhz) disable iff (reset)
      (trak.h_ck != $past(trak.h_ck)) |->
         ($past(trak.h_ck, 1) == $past(trak.h_ck, 2) &&
          $past(trak.h_ck, 2) == $past(trak.h_ck, 3)));

   a_v_ck_stable: assert property (@(posedge s_6mhz) disable iff (reset)
      (trak.v_ck != $past(trak.v_ck)) |->
         ($past(trak.v_ck, 1) == $past(trak.v_ck, 2) &&
          $past(trak.v_ck, 2) == $past(trak.v_ck, 3)));

endmodule

`default_nettype wire

// File: sim/io_model.svh
// reference model of the centipede I/O block, tracking latch, trackball counts and read bytes
`ifndef IO_MODEL_SVH
`define IO_MODEL_SVH

// model state, brought up to date once each access or pulse has settled
logic [7:0] latch_m;
trak_cnt_t  cnt_h_m;
trak_cnt_t  cnt_v_m;
logic       dir_h_m;
logic       dir_v_m;

function automatic void reset_model();
   latch_m = 8'h00;
   cnt_h_m = 4'h0;
   cnt_v_m = 4'h0;
   dir_h_m = 1'b0;
   dir_v_m = 1'b0;
endfunction

// out0 takes wdata bit 7 into the latch bit named by address bits 2:0
function automatic void latch_write(input io_addr_t addr, input io_data_t data);
   latch_m[addr[2:0]] = data[7];
endfunction

// steering clear leaves the direction bits alone
function automatic void clear_counts();
   cnt_h_m = 4'h0;
   cnt_v_m = 4'h0;
endfunction

// flip set selects player 1, the other player's pulses are lost
function automatic void count_pulse(input logic p1, input logic vert, input logic dir);
   if (p1 != latch_m[7])
      return;
   if (vert)
   begin
      dir_v_m = dir;
      cnt_v_m = dir ? cnt_v_m + 4'd1 : cnt_v_m - 4'd1;
   end
   else
   begin
      dir_h_m = dir;
      cnt_h_m = dir ? cnt_h_m + 4'd1 : cnt_h_m - 4'd1;
   end
endfunction

function automatic logic [3:0] expected_led();
   return latch_m[6:3];
endfunction

// blocks 2 and 3 read back, everything else gives zero
function automatic io_data_t expected_read(input io_addr_t addr, input logic [9:0] pl,
   input logic [7:0] js, input io_data_t s1, input io_data_t s2, input logic vb);
   logic [3:0] blk;
   logic       coin_r;
   logic       coin_c;
   logic       coin_l;
   io_data_t   val;
   blk    = addr[13:10];
   coin_r = pl[9] | latch_m[2];
   coin_c = pl[8] | latch_m[1];
   coin_l = pl[7] | latch_m[1];
   val    = 8'h00;
   if (blk == 4'h2)
      val = addr[0] ? s2 : s1;
   else if (blk == 4'h3 && !addr[1])
      val = addr[0] ? {coin_r, coin_c, coin_l, pl[4], pl[1], pl[0], pl[3], pl[2]}
                    : {dir_h_m, vb, pl[6], pl[5], cnt_h_m};
   else if (blk == 4'h3)
      val = addr[0] ? js : {dir_v_m, 3'b000, cnt_v_m};
   return val;
endfunction

`endif

// File: sim/tb_top.sv
// testbench for the centipede I/O block, random accesses and trackball pulses against a model
`default_nettype none
`timescale 1ns/100ps

module tb_top
   import io_pkg::*, bus_pkg::*;
();

   localparam int NUM_OPS = 400;

   logic       s_6mhz;
   logic       reset;
   cpu_bus_t   bus;
   logic [9:0] player;
   logic [7:0] trakball;
   logic [7:0] joystick;
   io_data_t   sw1;
   io_data_t   sw2;
   logic       vblank;
   io_data_t   rd_data;
   logic       rd_valid;
   logic [3:0] led;
   integer     seed;

   `include "io_model.svh"

   centipede_io dut (
      .s_6mhz     (s_6mhz),
      .reset      (reset),
      .bus_i      (bus),
      .player_i   (player),
      .trakball_i (trakball),
      .joystick_i (joystick),
      .sw1_i      (sw1),
      .sw2_i      (sw2),
      .vblank_i   (vblank),
      .rd_data_o  (rd_data),
      .rd_valid_o (rd_valid),
      .led_o      (led)
   );

   always #5 s_6mhz = ~s_6mhz;

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Something failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_data(input io_data_t got, input io_data_t want, input string what);
      if (got !== want)
         stop_on_error($sformatf("Mismatch at %0t: %s gave %02h, expected %02h",
                                 $time, what, got, want));
   endtask

   task automatic check_count(input trak_cnt_t got, input trak_cnt_t want, input string what);
      if (got !== want)
         stop_on_error($sformatf("Mismatch at %0t: %s gave %0d, expected %0d",
                                 $time, what, got, want));
   endtask

   task automatic check_led(input logic [3:0] got, input logic [3:0] want, input string what);
      if (got !== want)
         stop_on_error($sformatf("Mismatch at %0t: %s gave %b, expected %b",
                                 $time, what, got, want));
   endtask

   function automatic logic [31:0] next_random();
      return $random(seed);
   endfunction

   // blocks 2, 3, 7 and 9 are mapped, flipping bit 3 moves off them
   function automatic logic [3:0] unmapped_block(input logic [3:0] blk);
      if (blk == 4'h2 || blk == 4'h3 || blk == 4'h7 || blk == 4'h9)
         return blk ^ 4'h8;
      else
         return blk;
   endfunction

   // fresh input values with each read, held until the data comes back
   task automatic read_check(input io_addr_t addr);
      logic [31:0] r;
      io_data_t    want;
      int          waited;
      @(negedge s_6mhz);
      r = next_random();
      player   = r[9:0];
      joystick = r[17:10];
      sw1      = r[25:18];
      vblank   = r[26];
      r = next_random();
      sw2       = r[7:0];
      bus.addr  = addr;
      bus.wdata = r[15:8];
      bus.rd    = 1'b1;
      want = expected_read(addr, player, joystick, sw1, sw2, vblank);
      @(negedge s_6mhz);
      bus    = '0;
      waited = 0;
      while (!rd_valid && waited < 4)
      begin
         @(negedge s_6mhz);
         waited++;
      end
      if (!rd_valid)
         stop_on_error($sformatf("no read valid within 4 cycles of the read of %04h", addr));
      if (waited != 1)
         stop_on_error($sformatf("read valid for %04h not two cycles after the strobe", addr));
      check_data(rd_data, want, $sformatf("read of %04h", addr));
      if (addr[13:10] == 4'h3 && !addr[0])
         check_count(rd_data[3:0], addr[1] ? cnt_v_m : cnt_h_m, "trackball count");
      @(negedge s_6mhz);
      if (rd_valid)
         stop_on_error("read valid stayed high for more than one cycle");
   endtask

   task automatic write_access(input io_addr_t addr, input io_data_t data);
      @(negedge s_6mhz);
      bus.addr  = addr;
      bus.wdata = data;
      bus.wr    = 1'b1;
      @(negedge s_6mhz);
      bus = '0;
      // the write has landed two edges after the strobe
      repeat (2) @(negedge s_6mhz);
   endtask

   task automatic latch_bit_write(input logic [2:0] bitn, input logic val);
      logic [31:0] r;
      io_addr_t    addr;
      io_data_t    data;
      r    = next_random();
      addr = {4'h7, r[9:3], bitn};
      data = {val, r[16:10]};
      write_access(addr, data);
      latch_write(addr, data);
      check_led(led, expected_led(), "led after out0 write");
   endtask

   task automatic steer_clear();
      logic [31:0] r;
      r = next_random();
      write_access({4'h9, r[9:0]}, r[17:10]);
      clear_counts();
   endtask

   // dir settles a cycle before the clock rises, clock ends low
   task automatic trak_pulse(input logic p1, input logic vert, input logic dir);
      logic [2:0]  dir_bit;
      logic [2:0]  ck_bit;
      logic [31:0] r;
      dir_bit = vert ? {2'b01, p1} : {2'b11, p1};
      ck_bit  = vert ? {2'b00, p1} : {2'b10, p1};
      r = next_random();
      @(negedge s_6mhz);
      trakball[dir_bit] = dir;
      @(negedge s_6mhz);
      trakball[ck_bit] = 1'b1;
      repeat (4 + r[1:0]) @(negedge s_6mhz);
      trakball[ck_bit] = 1'b0;
      repeat (4 + r[3:2]) @(negedge s_6mhz);
      count_pulse(p1, vert, dir);
   endtask

   // every operation finishes well inside 20 cycles
   initial
   begin
      #(NUM_OPS * 20 * 10 + 5000);
      stop_on_error($sformatf("watchdog timeout, run not finished after %0t", $time));
   end

   initial
   begin
      logic [31:0] r;
      seed     = 32'h0fff_fd8b;
      s_6mhz   = 1'b0;
      reset    = 1'b1;
      bus      = '0;
      player   = '0;
      trakball = '0;
      joystick = '0;
      sw1      = '0;
      sw2      = '0;
      vblank   = 1'b0;
      reset_model();
      repeat (4) @(negedge s_6mhz);
      reset = 1'b0;
      if (rd_valid)
         stop_on_error("read valid set right after reset");
      check_led(led, 4'h0, "led after reset");
      read_check(14'h0C00);
      read_check(14'h0C02);

      // player select by flip, then steering clear and unmapped space
      trak_pulse(1'b0, 1'b0, 1'b1);
      trak_pulse(1'b1, 1'b0, 1'b1);
      read_check(14'h0C00);
      latch_bit_write(3'd7, 1'b1);
      trak_pulse(1'b1, 1'b1, 1'b0);
      trak_pulse(1'b0, 1'b1, 1'b1);
      read_check(14'h0C02);
      steer_clear();
      read_check(14'h0C00);
      read_check(14'h0C02);
      read_check(14'h3000);

      for (int i = 0; i < NUM_OPS; i++)
      begin
         r = next_random();
         case (r[3:0])
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5:
               read_check({4'h3, r[13:4]});
            4'd6:
               read_check({4'h2, r[13:4]});
            4'd7, 4'd8:
               latch_bit_write(r[6:4], r[7]);
            4'd9, 4'd10, 4'd11, 4'd12:
               trak_pulse(r[4], r[5], r[6]);
            4'd13:
               steer_clear();
            4'd14:
               read_check({unmapped_block(r[7:4]), r[17:8]});
            default:
               read_check({r[4] ? 4'h9 : 4'h7, r[17:8]});
         endcase
      end

      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb.f
+incdir+sim
common/io_pkg.sv
common/bus_pkg.sv
rtl/addr_decode.sv
rtl/coin_latch.sv
trakball/trak_sync.sv
trakball/trak_counter.sv
rtl/input_mux.sv
rtl/centipede_io.sv
sim/tb_top.sv

// File: Makefile
# Verilator simulation of the centipede I/O block

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f tb.f --top-module tb_top -o tb_top
	./obj_dir/tb_top | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
